/* radio_ctrl_pkg.sv */
// Register map, sizes and shared types for the radio-clock control plane.
// Imported by the daughterboard control, the front-panel GPIO mux and the top.
// The settings and readback offsets follow the daughterboard block layout.

package radio_ctrl_pkg;

   // --------------------------------------------------
   // sizes
   // --------------------------------------------------
   localparam int FP_GPIO_WIDTH = 12;   // front-panel pins
   localparam int NUM_DBOARDS   = 2;

   // --------------------------------------------------
   // types
   // --------------------------------------------------
   typedef logic [7:0]                 set_addr_t;  // settings and readback address
   typedef logic [31:0]                set_data_t;
   typedef logic [63:0]                rb_data_t;
   typedef logic [31:0]                gpio_t;      // db gpio, misc in and misc out
   typedef logic [FP_GPIO_WIDTH-1:0]   fp_gpio_t;
   typedef logic [2*FP_GPIO_WIDTH-1:0] fp_src_t;    // 2 bits per pin
   typedef logic [2:0]                 led_t;       // {RX, TXRX_TX, TXRX_RX}

   // --------------------------------------------------
   // settings bus addresses
   // --------------------------------------------------
   localparam set_addr_t SR_DB_BASE     = 8'd160;
   localparam set_addr_t SR_MISC_OUTS   = SR_DB_BASE + 8'd0;
   localparam set_addr_t SR_LEDS        = SR_DB_BASE + 8'd1;
   localparam set_addr_t SR_FP_GPIO_OUT = SR_DB_BASE + 8'd2;
   localparam set_addr_t SR_FP_GPIO_DDR = SR_DB_BASE + 8'd3;
   localparam set_addr_t SR_DB_GPIO_OUT = SR_DB_BASE + 8'd4;
   localparam set_addr_t SR_DB_GPIO_DDR = SR_DB_BASE + 8'd5;

   // front-panel source selects, only on daughterboard 0's bus
   localparam set_addr_t SR_FP_GPIO_SRC = 8'd96;

   // --------------------------------------------------
   // readback addresses
   // --------------------------------------------------
   localparam set_addr_t RB_DB_BASE = 8'd16;
   localparam set_addr_t RB_MISC_IO = RB_DB_BASE + 8'd0;  // {misc in, misc out}
   localparam set_addr_t RB_LEDS    = RB_DB_BASE + 8'd1;
   localparam set_addr_t RB_DB_GPIO = RB_DB_BASE + 8'd2;  // {gpio in, gpio out}
   localparam set_addr_t RB_FP_GPIO = RB_DB_BASE + 8'd3;  // {fp in, fp out request}

endpackage

/* db_control.sv */
// Control registers for one daughterboard on the radio clock.
// Decodes the SR_DB settings range into misc out, LED, front-panel and
// daughterboard GPIO registers, and answers strobe readback one cycle later.
// Misc inputs are registered once before they reach the readback word.

`timescale 1ns/10ps

module db_control import radio_ctrl_pkg::*; (
   input  logic      i_rst_n,
   input  logic      radio_clk,
   // settings bus
   input  logic      i_set_stb,
   input  set_addr_t i_set_addr,
   input  set_data_t i_set_data,
   // readback
   input  logic      i_rb_stb,
   input  set_addr_t i_rb_addr,
   output logic      o_rb_stb,
   output rb_data_t  o_rb_data,
   // misc io
   input  gpio_t     i_misc_in,
   output gpio_t     o_misc_out,
   output led_t      o_leds,
   // front-panel gpio request
   input  fp_gpio_t  i_fp_gpio_in,
   output fp_gpio_t  o_fp_gpio_out,
   output fp_gpio_t  o_fp_gpio_ddr,
   // daughterboard gpio
   input  gpio_t     i_db_gpio_in,
   output gpio_t     o_db_gpio_out,
   output gpio_t     o_db_gpio_ddr
);

   gpio_t    misc_in_r;   // one stage on the misc inputs
   rb_data_t rb_word;     // readback word before the output register

   // --------------------------------------------------
   // settings registers
   // --------------------------------------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_misc_out    <= '0;
         o_leds        <= '0;
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
         o_db_gpio_out <= '0;
         o_db_gpio_ddr <= '0;
      end else if (i_set_stb) begin
         case (i_set_addr)
            SR_MISC_OUTS: begin
               o_misc_out <= i_set_data;
            end
            SR_LEDS: begin
               o_leds <= i_set_data[2:0];
            end
            SR_FP_GPIO_OUT: begin
               o_fp_gpio_out <= i_set_data[FP_GPIO_WIDTH-1:0];
            end
            SR_FP_GPIO_DDR: begin
               o_fp_gpio_ddr <= i_set_data[FP_GPIO_WIDTH-1:0];
            end
            SR_DB_GPIO_OUT: begin
               o_db_gpio_out <= i_set_data;
            end
            SR_DB_GPIO_DDR: begin
               o_db_gpio_ddr <= i_set_data;
            end
            default: begin
               // other addresses belong to other blocks
            end
         endcase
      end
   end

   // --------------------------------------------------
   // misc input register
   // --------------------------------------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         misc_in_r <= '0;
      end else begin
         misc_in_r <= i_misc_in;
      end
   end

   // --------------------------------------------------
   // readback
   // --------------------------------------------------
   // register values as they stand before this edge's write
   always_comb begin
      case (i_rb_addr)
         RB_MISC_IO: begin
            rb_word = {misc_in_r, o_misc_out};
         end
         RB_LEDS: begin
            rb_word = rb_data_t'(o_leds);   // zero-extended
         end
         RB_DB_GPIO: begin
            rb_word = {i_db_gpio_in, o_db_gpio_out};
         end
         RB_FP_GPIO: begin
            rb_word = {gpio_t'(i_fp_gpio_in), gpio_t'(o_fp_gpio_out)};
         end
         default: begin
            rb_word = '0;   // unknown address reads zero
         end
      endcase
   end

   // one answer per request, so back-to-back requests pipeline
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_rb_stb  <= 1'b0;
         o_rb_data <= '0;
      end else begin
         o_rb_stb <= i_rb_stb;
         if (i_rb_stb) begin
            o_rb_data <= rb_word;
         end
      end
   end

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   // each request gets its answer on the next edge, with every data bit known
   a_rb_answer : assert property (
      @(posedge radio_clk) disable iff (!i_rst_n)
      i_rb_stb |=> (o_rb_stb && !$isunknown(o_rb_data))
   ) else $error("readback request without a known answer one cycle later");

endmodule

/* fp_gpio_mux.sv */
// Front-panel GPIO source mux.
// Holds the per-pin 2-bit source register, written on daughterboard 0's
// settings bus, and registers each pin's out and ddr from the selected
// daughterboard: field 0 picks daughterboard 0, any other value daughterboard 1.

`timescale 1ns/10ps

module fp_gpio_mux import radio_ctrl_pkg::*; (
   input  logic      i_rst_n,
   input  logic      radio_clk,
   // settings bus of daughterboard 0
   input  logic      i_set_stb,
   input  set_addr_t i_set_addr,
   input  set_data_t i_set_data,
   // requests from the two daughterboard controls
   input  fp_gpio_t  i_db0_out,
   input  fp_gpio_t  i_db0_ddr,
   input  fp_gpio_t  i_db1_out,
   input  fp_gpio_t  i_db1_ddr,
   // front-panel pins
   output fp_gpio_t  o_fp_gpio_out,
   output fp_gpio_t  o_fp_gpio_ddr
);

   fp_src_t  fp_src;    // 2 bits per pin
   fp_gpio_t sel_out;
   fp_gpio_t sel_ddr;

   // --------------------------------------------------
   // source register
   // --------------------------------------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         fp_src <= '0;
      end else if (i_set_stb && (i_set_addr == SR_FP_GPIO_SRC)) begin
         fp_src <= i_set_data[2*FP_GPIO_WIDTH-1:0];   // low 24 bits
      end
   end

   // --------------------------------------------------
   // per-pin select
   // --------------------------------------------------
   always_comb begin
      for (int i = 0; i < FP_GPIO_WIDTH; i++) begin
         if (fp_src[2*i +: 2] == 2'd0) begin
            sel_out[i] = i_db0_out[i];
            sel_ddr[i] = i_db0_ddr[i];
         end else begin
            // values 1 to 3 all map to daughterboard 1
            sel_out[i] = i_db1_out[i];
            sel_ddr[i] = i_db1_ddr[i];
         end
      end
   end

   // output stage, one cycle behind the select
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
      end else begin
         o_fp_gpio_out <= sel_out;
         o_fp_gpio_ddr <= sel_ddr;
      end
   end

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   // the source selects must be known on every edge once reset is released
   a_src_known : assert property (
      @(posedge radio_clk) disable iff (!i_rst_n)
      !$isunknown(fp_src)
   ) else $error("front-panel source register holds unknown bits");

endmodule

/* radio_ctrl_top.sv */
// Top level of the radio-clock control plane.
// Two daughterboard controls run side by side, each on its own settings and
// readback bus. Daughterboard 0's settings bus also feeds the front-panel mux.

`timescale 1ns/10ps

module radio_ctrl_top import radio_ctrl_pkg::*; (
   input  logic      i_rst_n,
   input  logic      radio_clk,
   // daughterboard 0 settings and readback
   input  logic      i_set0_stb,
   input  set_addr_t i_set0_addr,
   input  set_data_t i_set0_data,
   input  logic      i_rb0_stb,
   input  set_addr_t i_rb0_addr,
   output logic      o_rb0_stb,
   output rb_data_t  o_rb0_data,
   // daughterboard 1 settings and readback
   input  logic      i_set1_stb,
   input  set_addr_t i_set1_addr,
   input  set_data_t i_set1_data,
   input  logic      i_rb1_stb,
   input  set_addr_t i_rb1_addr,
   output logic      o_rb1_stb,
   output rb_data_t  o_rb1_data,
   // misc io and leds
   input  gpio_t     i_radio0_misc_in,
   input  gpio_t     i_radio1_misc_in,
   output gpio_t     o_radio0_misc_out,
   output gpio_t     o_radio1_misc_out,
   output led_t      o_radio_led0,
   output led_t      o_radio_led1,
   // front panel
   input  fp_gpio_t  i_fp_gpio_in,
   output fp_gpio_t  o_fp_gpio_out,
   output fp_gpio_t  o_fp_gpio_ddr,
   // daughterboard gpio
   input  gpio_t     i_db0_gpio_in,
   input  gpio_t     i_db1_gpio_in,
   output gpio_t     o_db0_gpio_out,
   output gpio_t     o_db1_gpio_out,
   output gpio_t     o_db0_gpio_ddr,
   output gpio_t     o_db1_gpio_ddr
);

   // front-panel requests from each daughterboard into the mux
   fp_gpio_t db_fp_out [NUM_DBOARDS];
   fp_gpio_t db_fp_ddr [NUM_DBOARDS];

   // --------------------------------------------------
   // daughterboard controls
   // --------------------------------------------------
   db_control db_control0 (
      .i_rst_n(i_rst_n), .radio_clk(radio_clk),
      .i_set_stb(i_set0_stb), .i_set_addr(i_set0_addr), .i_set_data(i_set0_data),
      .i_rb_stb(i_rb0_stb), .i_rb_addr(i_rb0_addr),
      .o_rb_stb(o_rb0_stb), .o_rb_data(o_rb0_data),
      .i_misc_in(i_radio0_misc_in), .o_misc_out(o_radio0_misc_out),
      .o_leds(o_radio_led0),
      .i_fp_gpio_in(i_fp_gpio_in),   // fp inputs go to both boards
      .o_fp_gpio_out(db_fp_out[0]), .o_fp_gpio_ddr(db_fp_ddr[0]),
      .i_db_gpio_in(i_db0_gpio_in),
      .o_db_gpio_out(o_db0_gpio_out), .o_db_gpio_ddr(o_db0_gpio_ddr)
   );

   db_control db_control1 (
      .i_rst_n(i_rst_n), .radio_clk(radio_clk),
      .i_set_stb(i_set1_stb), .i_set_addr(i_set1_addr), .i_set_data(i_set1_data),
      .i_rb_stb(i_rb1_stb), .i_rb_addr(i_rb1_addr),
      .o_rb_stb(o_rb1_stb), .o_rb_data(o_rb1_data),
      .i_misc_in(i_radio1_misc_in), .o_misc_out(o_radio1_misc_out),
      .o_leds(o_radio_led1),
      .i_fp_gpio_in(i_fp_gpio_in),
      .o_fp_gpio_out(db_fp_out[1]), .o_fp_gpio_ddr(db_fp_ddr[1]),
      .i_db_gpio_in(i_db1_gpio_in),
      .o_db_gpio_out(o_db1_gpio_out), .o_db_gpio_ddr(o_db1_gpio_ddr)
   );

   // --------------------------------------------------
   // front-panel source mux
   // --------------------------------------------------
   fp_gpio_mux fp_gpio_mux0 (
      .i_rst_n(i_rst_n), .radio_clk(radio_clk),
      .i_set_stb(i_set0_stb), .i_set_addr(i_set0_addr), .i_set_data(i_set0_data),
      .i_db0_out(db_fp_out[0]), .i_db0_ddr(db_fp_ddr[0]),
      .i_db1_out(db_fp_out[1]), .i_db1_ddr(db_fp_ddr[1]),
      .o_fp_gpio_out(o_fp_gpio_out), .o_fp_gpio_ddr(o_fp_gpio_ddr)
   );

endmodule

/* radio_ctrl_checker.sv */
// Scoreboard for the radio control top level.
// Keeps its own model of both daughterboard register sets and the front-panel
// mux, steps it on each rising edge and compares the DUT outputs on the
// falling edge. The error counts go back to the testbench top.

`timescale 1ns/10ps

module radio_ctrl_checker import radio_ctrl_pkg::*; (
   input  logic      i_rst_n,
   input  logic      radio_clk,
   // stimulus as driven into the DUT
   input  logic      i_set0_stb, i_set1_stb, i_rb0_stb, i_rb1_stb,
   input  set_addr_t i_set0_addr, i_set1_addr, i_rb0_addr, i_rb1_addr,
   input  set_data_t i_set0_data, i_set1_data,
   input  gpio_t     i_radio0_misc_in, i_radio1_misc_in,
   input  gpio_t     i_db0_gpio_in, i_db1_gpio_in,
   input  fp_gpio_t  i_fp_gpio_in,
   // DUT outputs under watch
   input  logic      i_dut_rb0_stb, i_dut_rb1_stb,
   input  rb_data_t  i_dut_rb0_data, i_dut_rb1_data,
   input  gpio_t     i_dut_radio0_misc_out, i_dut_radio1_misc_out,
   input  led_t      i_dut_radio_led0, i_dut_radio_led1,
   input  fp_gpio_t  i_dut_fp_gpio_out, i_dut_fp_gpio_ddr,
   input  gpio_t     i_dut_db0_gpio_out, i_dut_db1_gpio_out,
   input  gpio_t     i_dut_db0_gpio_ddr, i_dut_db1_gpio_ddr,
   output int        o_value_errors,
   output int        o_stb_errors
);

   gpio_t    m_misc_out [NUM_DBOARDS];
   led_t     m_leds [NUM_DBOARDS];
   fp_gpio_t m_fp_out [NUM_DBOARDS];   // front-panel requests
   fp_gpio_t m_fp_ddr [NUM_DBOARDS];
   gpio_t    m_db_out [NUM_DBOARDS];
   gpio_t    m_db_ddr [NUM_DBOARDS];
   gpio_t    m_misc_in_r [NUM_DBOARDS];
   logic     exp_rb_stb [NUM_DBOARDS];
   rb_data_t exp_rb_data [NUM_DBOARDS];
   fp_src_t  m_src;
   fp_gpio_t exp_fp_out;
   fp_gpio_t exp_fp_ddr;
   int       value_errors = 0;
   int       stb_errors = 0;

   assign o_value_errors = value_errors;
   assign o_stb_errors   = stb_errors;

   // --------------------------------------------------
   // model of one daughterboard for one rising edge
   // --------------------------------------------------
   task automatic step_board(input int b, input logic set_stb, input set_addr_t set_addr,
                             input set_data_t set_data, input logic rb_stb,
                             input set_addr_t rb_addr, input gpio_t misc_in,
                             input gpio_t db_in);
      rb_data_t word;
      // answer is built from the registers before this edge's write
      case (rb_addr)
         RB_MISC_IO: word = {m_misc_in_r[b], m_misc_out[b]};
         RB_LEDS:    word = {61'd0, m_leds[b]};
         RB_DB_GPIO: word = {db_in, m_db_out[b]};
         RB_FP_GPIO: word = {20'd0, i_fp_gpio_in, 20'd0, m_fp_out[b]};
         default:    word = '0;
      endcase
      exp_rb_stb[b]  = rb_stb;
      exp_rb_data[b] = word;
      m_misc_in_r[b] = misc_in;
      if (set_stb) begin
         case (set_addr)
            SR_MISC_OUTS:   m_misc_out[b] = set_data;
            SR_LEDS:        m_leds[b] = set_data[2:0];
            SR_FP_GPIO_OUT: m_fp_out[b] = set_data[FP_GPIO_WIDTH-1:0];
            SR_FP_GPIO_DDR: m_fp_ddr[b] = set_data[FP_GPIO_WIDTH-1:0];
            SR_DB_GPIO_OUT: m_db_out[b] = set_data;
            SR_DB_GPIO_DDR: m_db_ddr[b] = set_data;
            default:        ;   // not a db register
         endcase
      end
   endtask

   always @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int b = 0; b < NUM_DBOARDS; b++) begin
            m_misc_out[b]  = '0;
            m_leds[b]      = '0;
            m_fp_out[b]    = '0;
            m_fp_ddr[b]    = '0;
            m_db_out[b]    = '0;
            m_db_ddr[b]    = '0;
            m_misc_in_r[b] = '0;
            exp_rb_stb[b]  = 1'b0;
            exp_rb_data[b] = '0;
         end
         m_src      = '0;
         exp_fp_out = '0;
         exp_fp_ddr = '0;
      end else begin
         // mux output stage takes the selects and requests from before this edge
         for (int i = 0; i < FP_GPIO_WIDTH; i++) begin
            exp_fp_out[i] = (m_src[2*i +: 2] == 2'd0) ? m_fp_out[0][i] : m_fp_out[1][i];
            exp_fp_ddr[i] = (m_src[2*i +: 2] == 2'd0) ? m_fp_ddr[0][i] : m_fp_ddr[1][i];
         end
         if (i_set0_stb && (i_set0_addr == SR_FP_GPIO_SRC)) begin
            m_src = i_set0_data[2*FP_GPIO_WIDTH-1:0];   // bus 0 only
         end
         step_board(0, i_set0_stb, i_set0_addr, i_set0_data, i_rb0_stb, i_rb0_addr,
                    i_radio0_misc_in, i_db0_gpio_in);
         step_board(1, i_set1_stb, i_set1_addr, i_set1_data, i_rb1_stb, i_rb1_addr,
                    i_radio1_misc_in, i_db1_gpio_in);
      end
   end

   // --------------------------------------------------
   // comparison
   // --------------------------------------------------
   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      if (act !== exp) begin
         value_errors++;
         $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_readback(input int b, input logic stb, input rb_data_t data);
      if (stb !== exp_rb_stb[b]) begin
         stb_errors++;
         if (exp_rb_stb[b]) begin
            $display("at %0t: readback answer on board %0d did not arrive", $time, b);
         end else begin
            $display("at %0t: readback strobe on board %0d without a request", $time, b);
         end
      end else if (stb) begin
         check_value($sformatf("o_rb%0d_data", b), exp_rb_data[b], data);
      end
   endtask

   always @(negedge radio_clk) begin
      check_value("o_radio0_misc_out", 64'(m_misc_out[0]), 64'(i_dut_radio0_misc_out));
      check_value("o_radio1_misc_out", 64'(m_misc_out[1]), 64'(i_dut_radio1_misc_out));
      check_value("o_radio_led0", 64'(m_leds[0]), 64'(i_dut_radio_led0));
      check_value("o_radio_led1", 64'(m_leds[1]), 64'(i_dut_radio_led1));
      check_value("o_db0_gpio_out", 64'(m_db_out[0]), 64'(i_dut_db0_gpio_out));
      check_value("o_db1_gpio_out", 64'(m_db_out[1]), 64'(i_dut_db1_gpio_out));
      check_value("o_db0_gpio_ddr", 64'(m_db_ddr[0]), 64'(i_dut_db0_gpio_ddr));
      check_value("o_db1_gpio_ddr", 64'(m_db_ddr[1]), 64'(i_dut_db1_gpio_ddr));
      check_value("o_fp_gpio_out", 64'(exp_fp_out), 64'(i_dut_fp_gpio_out));
      check_value("o_fp_gpio_ddr", 64'(exp_fp_ddr), 64'(i_dut_fp_gpio_ddr));
      check_readback(0, i_dut_rb0_stb, i_dut_rb0_data);
      check_readback(1, i_dut_rb1_stb, i_dut_rb1_data);
   end

endmodule

/* radio_ctrl_tb.sv */
// Testbench for the radio control top level.
// Random settings writes, readbacks and input changes come from an LFSR;
// radio_ctrl_checker models the registers and compares every DUT output.

`timescale 1ns/10ps

module radio_ctrl_tb import radio_ctrl_pkg::*; ();

   localparam int RESET_CYCLES   = 16;
   localparam int RUN_CYCLES     = 3000;
   localparam int DRAIN_CYCLES   = 4;
   localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 3;   // a third of headroom

   logic      radio_clk;
   logic      i_rst_n = 1'b0;
   logic      i_set0_stb = 1'b0, i_set1_stb = 1'b0, i_rb0_stb = 1'b0, i_rb1_stb = 1'b0;
   set_addr_t i_set0_addr = '0, i_set1_addr = '0, i_rb0_addr = '0, i_rb1_addr = '0;
   set_data_t i_set0_data = '0, i_set1_data = '0;
   gpio_t     i_radio0_misc_in = '0, i_radio1_misc_in = '0;
   gpio_t     i_db0_gpio_in = '0, i_db1_gpio_in = '0;
   fp_gpio_t  i_fp_gpio_in = '0;
   // DUT outputs
   logic      o_rb0_stb, o_rb1_stb;
   rb_data_t  o_rb0_data, o_rb1_data;
   gpio_t     o_radio0_misc_out, o_radio1_misc_out;
   led_t      o_radio_led0, o_radio_led1;
   fp_gpio_t  o_fp_gpio_out, o_fp_gpio_ddr;
   gpio_t     o_db0_gpio_out, o_db1_gpio_out, o_db0_gpio_ddr, o_db1_gpio_ddr;

   logic [31:0] lfsr = 32'hac6fa842;
   int          cycle_count = 0;
   int          value_errors;
   int          stb_errors;

   radio_ctrl_top dut0 (.*);

   radio_ctrl_checker checker0 (
      .i_dut_rb0_stb(o_rb0_stb), .i_dut_rb1_stb(o_rb1_stb),
      .i_dut_rb0_data(o_rb0_data), .i_dut_rb1_data(o_rb1_data),
      .i_dut_radio0_misc_out(o_radio0_misc_out), .i_dut_radio1_misc_out(o_radio1_misc_out),
      .i_dut_radio_led0(o_radio_led0), .i_dut_radio_led1(o_radio_led1),
      .i_dut_fp_gpio_out(o_fp_gpio_out), .i_dut_fp_gpio_ddr(o_fp_gpio_ddr),
      .i_dut_db0_gpio_out(o_db0_gpio_out), .i_dut_db1_gpio_out(o_db1_gpio_out),
      .i_dut_db0_gpio_ddr(o_db0_gpio_ddr), .i_dut_db1_gpio_ddr(o_db1_gpio_ddr),
      .o_value_errors(value_errors), .o_stb_errors(stb_errors),
      .*
   );

   initial begin
      radio_clk = 1'b0;
      forever #4 radio_clk = ~radio_clk;   // 8 ns period
   end

   always @(posedge radio_clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: run still going after %0d cycles", cycle_count);
         $display(">>> FAIL");
         $finish;
      end
   end

   // --------------------------------------------------
   // random numbers
   // --------------------------------------------------
   // fibonacci LFSR, taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int k = 0; k < n; k++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic set_addr_t pick_set_addr();
      logic [31:0] k;
      logic [31:0] r;
      set_addr_t   a;
      k = take_bits(4);
      if (k < 12) begin
         a = SR_DB_BASE + set_addr_t'(k % 6);   // one of the six db registers
      end else if (k < 14) begin
         a = SR_FP_GPIO_SRC;
      end else begin
         r = take_bits(8);
         a = r[7:0];   // stray
      end
      return a;
   endfunction

   function automatic set_addr_t pick_rb_addr();
      logic [31:0] k;
      logic [31:0] r;
      set_addr_t   a;
      k = take_bits(3);
      if (k < 6) begin
         a = RB_DB_BASE + set_addr_t'(k % 4);
      end else begin
         r = take_bits(8);
         a = r[7:0];   // mostly unknown, reads zero
      end
      return a;
   endfunction

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------
   task automatic drive_cycle();
      logic [31:0] r;
      r = take_bits(1);
      i_set0_stb  = r[0];
      i_set0_addr = pick_set_addr();
      i_set0_data = take_bits(32);
      r = take_bits(1);
      i_set1_stb  = r[0];
      i_set1_addr = pick_set_addr();
      i_set1_data = take_bits(32);
      r = take_bits(2);
      i_rb0_stb  = (r != 0);   // mostly on, so requests run back to back
      i_rb0_addr = pick_rb_addr();
      r = take_bits(2);
      i_rb1_stb  = (r != 0);
      i_rb1_addr = pick_rb_addr();
      r = take_bits(3);
      case (r[2:0])
         3'd0: i_radio0_misc_in = take_bits(32);
         3'd1: i_radio1_misc_in = take_bits(32);
         3'd2: i_db0_gpio_in = take_bits(32);
         3'd3: i_db1_gpio_in = take_bits(32);
         3'd4: begin
            r = take_bits(FP_GPIO_WIDTH);
            i_fp_gpio_in = r[FP_GPIO_WIDTH-1:0];
         end
         default: ;   // inputs hold
      endcase
   endtask

   initial begin
      repeat (RESET_CYCLES) @(posedge radio_clk);
      #1;
      i_rst_n = 1'b1;
      repeat (RUN_CYCLES) begin
         @(posedge radio_clk);
         #1;
         drive_cycle();
      end
      @(posedge radio_clk);
      #1;
      i_set0_stb = 1'b0;
      i_set1_stb = 1'b0;
      i_rb0_stb  = 1'b0;
      i_rb1_stb  = 1'b0;
      repeat (DRAIN_CYCLES) @(posedge radio_clk);
      @(negedge radio_clk);   // last compare done
      $display("closing: %0d value mismatches, %0d readback strobe errors",
               value_errors, stb_errors);
      if ((value_errors + stb_errors) == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* files.f */
radio_ctrl_pkg.sv
db_control.sv
fp_gpio_mux.sv
radio_ctrl_top.sv
radio_ctrl_checker.sv
radio_ctrl_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the radio control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --timescale 1ns/10ps \
   --top-module radio_ctrl_tb \
   -f files.f \
   -o sim_radio_ctrl

./obj_dir/sim_radio_ctrl 2>&1 | tee sim.log

if grep -q ">>> FAIL" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
   echo "simulation ended without a verdict"
   exit 1
fi
echo "simulation passed"
